/* mult_macros.svh */
/*
  multiplier constants
  widths shared by the sequencer and the datapaths, fixed by the ISA
*/

`ifndef MULT_MACROS_SVH
`define MULT_MACROS_SVH

// full data word
`define MULT_DW 32

// halfword, one subword operand of the short multiplier
`define MULT_HW 16

// byte, one lane of the 8-bit dot product
`define MULT_BW 8

// operator code width
`define MULT_OPW 4

// shift immediate, covers 0..31
`define MULT_IMMW 5

`endif

/* mult_op_pkg.sv */
/*
  multiplier operator package
  operator codes and the operand signedness modes seen by the datapaths
*/

`include "mult_macros.svh"

package mult_op_pkg;

  // operator codes from the decoder
  // any code not listed returns zero
  typedef enum logic [`MULT_OPW-1:0] {
    // 32x32 accumulate, low word
    MUL_MAC32 = 4'd0,
    // 32x32 subtract from accumulator, low word
    MUL_MSU32 = 4'd1,
    // 16x16 accumulate with right shift
    MUL_I     = 4'd2,
    // same, rounded before the shift
    MUL_IR    = 4'd3,
    // upper word of 32x32, multicycle
    MUL_H     = 4'd4,
    // four byte products plus accumulator
    MUL_DOT8  = 4'd5,
    // two halfword products plus accumulator
    MUL_DOT16 = 4'd6
  } mult_op_e;

  // bit 0 marks operand a signed, bit 1 marks operand b signed
  // b signed with a unsigned is never issued
  typedef enum logic [1:0] {
    SGN_UU = 2'b00,
    SGN_SU = 2'b01,
    SGN_SS = 2'b11
  } sign_mode_e;

endpackage

/* mult_ctrl_pkg.sv */
/*
  multiplier control package
  state encoding of the upper-half product sequencer
*/

package mult_ctrl_pkg;

  // upper-half sequence
  // idle -> three partial steps -> finish, held until the core takes it
  typedef enum logic [2:0] {
    // single-cycle operators pass straight through
    MH_IDLE   = 3'd0,
    // a_lo * b_lo, shifted down by a halfword
    MH_STEP0  = 3'd1,
    // a_lo * b_hi, carry kept as sign extension
    MH_STEP1  = 3'd2,
    // a_hi * b_lo, shifted down by a halfword
    MH_STEP2  = 3'd3,
    // a_hi * b_hi, final upper word valid
    MH_FINISH = 3'd4
  } mulh_state_e;

endpackage

/* mulh_seq.sv */
/*
  upper-half product sequencer
  walks the four partial products of a 32x32 upper-word multiply and
  drives the subword controls of the short multiplier, plus ready/multicycle
*/

`timescale 1ns/1ps

`include "mult_macros.svh"

module mulh_seq
  import mult_op_pkg::*;
  import mult_ctrl_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,

  input  logic                  enable_i,
  input  mult_op_e              operator_i,
  input  logic                  short_subword_i,
  input  sign_mode_e            short_signed_i,
  input  logic [`MULT_IMMW-1:0] imm_i,
  input  logic                  ex_ready_i,

  output logic [1:0]            sub_sel_o,
  output logic [1:0]            sub_signed_o,
  output logic [`MULT_IMMW-1:0] sub_imm_o,
  output logic                  shift_arith_o,
  output logic                  mulh_active_o,
  output logic                  carry_save_o,
  output logic                  carry_clear_o,
  output logic                  ready_o,
  output logic                  multicycle_o
);

  mulh_state_e state_q;
  mulh_state_e state_d;
  logic        mh_start;

  // new upper-half request accepted only from idle
  assign mh_start = (state_q == MH_IDLE) && enable_i && (operator_i == MUL_H);

  always_comb begin
    state_d       = state_q;
    sub_sel_o     = 2'b00;
    sub_signed_o  = SGN_UU;
    sub_imm_o     = '0;
    shift_arith_o = 1'b0;
    mulh_active_o = 1'b1;
    carry_save_o  = 1'b0;
    carry_clear_o = 1'b0;
    ready_o       = 1'b0;
    multicycle_o  = 1'b0;

    case (state_q)
      MH_IDLE: begin
        // caller's subword controls, same half on both operands
        sub_sel_o     = {2{short_subword_i}};
        sub_signed_o  = short_signed_i;
        sub_imm_o     = imm_i;
        shift_arith_o = short_signed_i[0];
        mulh_active_o = 1'b0;
        ready_o       = !mh_start;
        if (mh_start) begin
          state_d = MH_STEP0;
        end
      end

      MH_STEP0: begin
        // lo*lo fits in 32 bits unsigned, saved carry is zero
        multicycle_o = 1'b1;
        sub_imm_o    = `MULT_IMMW'(`MULT_HW);
        carry_save_o = 1'b1;
        state_d      = MH_STEP1;
      end

      MH_STEP1: begin
        // a_lo * b_hi, signed only through b
        multicycle_o  = 1'b1;
        sub_sel_o     = 2'b10;
        sub_signed_o  = {short_signed_i[1], 1'b0};
        shift_arith_o = 1'b1;
        carry_save_o  = 1'b1;
        state_d       = MH_STEP2;
      end

      MH_STEP2: begin
        // a_hi * b_lo, signed only through a
        // bits above 32 drop out with the shift, so no carry kept
        multicycle_o  = 1'b1;
        sub_sel_o     = 2'b01;
        sub_signed_o  = {1'b0, short_signed_i[0]};
        sub_imm_o     = `MULT_IMMW'(`MULT_HW);
        shift_arith_o = 1'b1;
        carry_save_o  = 1'b1;
        carry_clear_o = 1'b1;
        state_d       = MH_FINISH;
      end

      MH_FINISH: begin
        // hi*hi with the caller's signedness gives the upper word
        sub_sel_o    = 2'b11;
        sub_signed_o = short_signed_i;
        ready_o      = 1'b1;
        if (ex_ready_i) begin
          state_d = MH_IDLE;
        end
      end

      default: begin
        state_d = MH_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= MH_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  ////////////////////////////////////////
  // checks
  ////////////////////////////////////////

  // three multicycle steps, then the result is offered
  a_mulh_steps: assert property (@(posedge clk) disable iff (!rst_n)
    mh_start |=> multicycle_o ##1 multicycle_o ##1 multicycle_o
      ##1 (!multicycle_o && ready_o && state_q == MH_FINISH));

  // result held until the core takes it
  a_finish_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (state_q == MH_FINISH && !ex_ready_i) |=> (state_q == MH_FINISH && ready_o));

endmodule

/* short_mac.sv */
/*
  subword multiply-accumulate
  17x17 signed multiply of selected halfwords, accumulate, rounding and
  right shift; keeps the partial sum and carry for upper-half products
*/

`timescale 1ns/1ps

`include "mult_macros.svh"

module short_mac
  import mult_op_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,

  input  mult_op_e              operator_i,
  input  logic [`MULT_DW-1:0]   op_a_i,
  input  logic [`MULT_DW-1:0]   op_b_i,
  input  logic [`MULT_DW-1:0]   op_c_i,
  input  logic [`MULT_IMMW-1:0] imm_i,

  input  logic [1:0]            sub_sel_i,
  input  logic [1:0]            sub_signed_i,
  input  logic [`MULT_IMMW-1:0] sub_imm_i,
  input  logic                  shift_arith_i,
  input  logic                  mulh_active_i,
  input  logic                  carry_save_i,
  input  logic                  carry_clear_i,
  input  logic                  ex_ready_i,

  output logic [`MULT_DW-1:0]   short_result_o
);

  logic        [`MULT_HW-1:0] half_a;
  logic        [`MULT_HW-1:0] half_b;
  logic signed [`MULT_HW:0]   op_a_ext;
  logic signed [`MULT_HW:0]   op_b_ext;
  logic signed [`MULT_DW+1:0] product;
  logic signed [`MULT_DW+1:0] acc_ext;
  logic signed [`MULT_DW+1:0] mac_sum;
  logic signed [`MULT_DW+1:0] shift_in;
  logic signed [`MULT_DW+1:0] shift_out;
  logic        [`MULT_DW-1:0] round_pow;
  logic        [`MULT_DW-1:0] round_val;
  logic                       msb_hi;
  logic                       msb_lo;
  logic                       carry_q;
  logic        [`MULT_DW-1:0] partial_q;

  // halfword select, bit 0 for a and bit 1 for b
  assign half_a = sub_sel_i[0] ? op_a_i[`MULT_DW-1:`MULT_HW] : op_a_i[`MULT_HW-1:0];
  assign half_b = sub_sel_i[1] ? op_b_i[`MULT_DW-1:`MULT_HW] : op_b_i[`MULT_HW-1:0];

  // 17th bit carries the sign or a zero
  assign op_a_ext = {sub_signed_i[0] & half_a[`MULT_HW-1], half_a};
  assign op_b_ext = {sub_signed_i[1] & half_b[`MULT_HW-1], half_b};

  // upper-half steps accumulate onto the saved partial, carry as its sign
  assign acc_ext = mulh_active_i ? {carry_q, carry_q, partial_q}
                                 : {{2{op_c_i[`MULT_DW-1]}}, op_c_i};

  assign product = op_a_ext * op_b_ext;

  // half an lsb of the shifted result, zero for a shift of 0
  assign round_pow = {{(`MULT_DW-1){1'b0}}, 1'b1} << imm_i;
  assign round_val = (operator_i == MUL_IR) ? {1'b0, round_pow[`MULT_DW-1:1]} : '0;

  assign mac_sum = acc_ext + product + $signed({2'b00, round_val});

  // single-cycle ops sign-extend from bit 31, upper-half steps keep 34 bits
  assign msb_hi = mulh_active_i ? mac_sum[`MULT_DW+1] : mac_sum[`MULT_DW-1];
  assign msb_lo = mulh_active_i ? mac_sum[`MULT_DW]   : mac_sum[`MULT_DW-1];

  assign shift_in  = {shift_arith_i & msb_hi, shift_arith_i & msb_lo,
                      mac_sum[`MULT_DW-1:0]};
  assign shift_out = shift_in >>> sub_imm_i;

  assign short_result_o = shift_out[`MULT_DW-1:0];

  // partial sum and carry between the upper-half steps
  // dropped once the core moves on
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      carry_q   <= 1'b0;
      partial_q <= '0;
    end else if (carry_save_i) begin
      carry_q   <= ~carry_clear_i & mac_sum[`MULT_DW];
      partial_q <= short_result_o;
    end else if (ex_ready_i) begin
      carry_q   <= 1'b0;
      partial_q <= '0;
    end
  end

  // sequencer only clears the carry within a save step
  a_clear_in_save: assert property (@(posedge clk) disable iff (!rst_n)
    carry_clear_i |-> carry_save_i);

endmodule

/* word_mac.sv */
/*
  word multiply-accumulate and result select
  32x32 mac/msu, byte and halfword dot products, operator-driven output mux
*/

`timescale 1ns/1ps

`include "mult_macros.svh"

module word_mac
  import mult_op_pkg::*;
(
  input  mult_op_e            operator_i,
  input  sign_mode_e          dot_signed_i,
  input  logic [`MULT_DW-1:0] op_a_i,
  input  logic [`MULT_DW-1:0] op_b_i,
  input  logic [`MULT_DW-1:0] op_c_i,
  input  logic [`MULT_DW-1:0] short_result_i,

  output logic [`MULT_DW-1:0] result_o
);

  localparam int unsigned NUM_BYTES = `MULT_DW / `MULT_BW;
  localparam int unsigned NUM_HALVES = `MULT_DW / `MULT_HW;

  ////////////////////////////////////////
  // integer mac / msu
  ////////////////////////////////////////

  logic                int_is_msu;
  logic [`MULT_DW-1:0] int_op_a;
  logic [`MULT_DW-1:0] int_op_b_add;
  logic [`MULT_DW-1:0] int_result;

  assign int_is_msu = (operator_i == MUL_MSU32);

  // -a*b = ~a*b + b, low word only so signedness does not matter
  assign int_op_a     = op_a_i ^ {`MULT_DW{int_is_msu}};
  assign int_op_b_add = op_b_i & {`MULT_DW{int_is_msu}};

  assign int_result = op_c_i + int_op_b_add + int_op_a * op_b_i;

  ////////////////////////////////////////
  // dot products
  ////////////////////////////////////////

  logic signed [`MULT_BW:0]     char_a;
  logic signed [`MULT_BW:0]     char_b;
  logic signed [2*`MULT_BW+1:0] char_prod;
  logic        [`MULT_DW-1:0]   dot8_result;

  logic signed [`MULT_HW:0]     half_a;
  logic signed [`MULT_HW:0]     half_b;
  logic signed [2*`MULT_HW+1:0] half_prod;
  logic        [`MULT_DW-1:0]   dot16_result;

  // byte lanes, each extended by its operand's sign mode
  always_comb begin
    char_a      = '0;
    char_b      = '0;
    char_prod   = '0;
    dot8_result = op_c_i;
    for (int unsigned i = 0; i < NUM_BYTES; i++) begin
      char_a = {dot_signed_i[0] & op_a_i[`MULT_BW*i+`MULT_BW-1], op_a_i[`MULT_BW*i +: `MULT_BW]};
      char_b = {dot_signed_i[1] & op_b_i[`MULT_BW*i+`MULT_BW-1], op_b_i[`MULT_BW*i +: `MULT_BW]};
      char_prod = char_a * char_b;
      // sign-extend the 18-bit lane product onto the sum
      dot8_result = dot8_result +
                    {{(`MULT_DW-2*`MULT_BW-2){char_prod[2*`MULT_BW+1]}}, char_prod};
    end
  end

  // halfword lanes, products truncated to the word
  always_comb begin
    half_a       = '0;
    half_b       = '0;
    half_prod    = '0;
    dot16_result = op_c_i;
    for (int unsigned i = 0; i < NUM_HALVES; i++) begin
      half_a = {dot_signed_i[0] & op_a_i[`MULT_HW*i+`MULT_HW-1], op_a_i[`MULT_HW*i +: `MULT_HW]};
      half_b = {dot_signed_i[1] & op_b_i[`MULT_HW*i+`MULT_HW-1], op_b_i[`MULT_HW*i +: `MULT_HW]};
      half_prod    = half_a * half_b;
      dot16_result = dot16_result + half_prod[`MULT_DW-1:0];
    end
  end

  ////////////////////////////////////////
  // result select
  ////////////////////////////////////////

  always_comb begin
    unique case (operator_i)
      MUL_MAC32, MUL_MSU32:  result_o = int_result;
      // short path also carries the upper-half product
      MUL_I, MUL_IR, MUL_H:  result_o = short_result_i;
      MUL_DOT8:              result_o = dot8_result;
      MUL_DOT16:             result_o = dot16_result;
      default:               result_o = '0;
    endcase
  end

endmodule

/* mult_top.sv */
/*
  multiply / mac unit top
  upper-half sequencer feeding the subword datapath, word datapath
  selects the final result
*/

`timescale 1ns/1ps

`include "mult_macros.svh"

module mult_top
  import mult_op_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,

  input  logic                  enable_i,
  input  mult_op_e              operator_i,
  input  logic                  short_subword_i,
  input  sign_mode_e            short_signed_i,
  input  sign_mode_e            dot_signed_i,
  input  logic [`MULT_DW-1:0]   op_a_i,
  input  logic [`MULT_DW-1:0]   op_b_i,
  input  logic [`MULT_DW-1:0]   op_c_i,
  input  logic [`MULT_IMMW-1:0] imm_i,
  input  logic                  ex_ready_i,

  output logic [`MULT_DW-1:0]   result_o,
  output logic                  ready_o,
  output logic                  multicycle_o
);

  // effective subword controls
  logic [1:0]            sub_sel;
  logic [1:0]            sub_signed;
  logic [`MULT_IMMW-1:0] sub_imm;
  logic                  shift_arith;

  // upper-half bookkeeping
  logic                  mulh_active;
  logic                  carry_save;
  logic                  carry_clear;

  logic [`MULT_DW-1:0]   short_result;

  mulh_seq mulh_seq_i (
    .clk             (clk),
    .rst_n           (rst_n),
    .enable_i        (enable_i),
    .operator_i      (operator_i),
    .short_subword_i (short_subword_i),
    .short_signed_i  (short_signed_i),
    .imm_i           (imm_i),
    .ex_ready_i      (ex_ready_i),
    .sub_sel_o       (sub_sel),
    .sub_signed_o    (sub_signed),
    .sub_imm_o       (sub_imm),
    .shift_arith_o   (shift_arith),
    .mulh_active_o   (mulh_active),
    .carry_save_o    (carry_save),
    .carry_clear_o   (carry_clear),
    .ready_o         (ready_o),
    .multicycle_o    (multicycle_o)
  );

  short_mac short_mac_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .operator_i     (operator_i),
    .op_a_i         (op_a_i),
    .op_b_i         (op_b_i),
    .op_c_i         (op_c_i),
    .imm_i          (imm_i),
    .sub_sel_i      (sub_sel),
    .sub_signed_i   (sub_signed),
    .sub_imm_i      (sub_imm),
    .shift_arith_i  (shift_arith),
    .mulh_active_i  (mulh_active),
    .carry_save_i   (carry_save),
    .carry_clear_i  (carry_clear),
    .ex_ready_i     (ex_ready_i),
    .short_result_o (short_result)
  );

  word_mac word_mac_i (
    .operator_i     (operator_i),
    .dot_signed_i   (dot_signed_i),
    .op_a_i         (op_a_i),
    .op_b_i         (op_b_i),
    .op_c_i         (op_c_i),
    .short_result_i (short_result),
    .result_o       (result_o)
  );

endmodule

/* tb_mult_top.sv */
/*
  testbench for the multiply / mac unit
  random stimulus per operator class, checked against reference models
  by concurrent assertions sampled on the falling clock edge
*/

`timescale 1ns/1ps

`include "mult_macros.svh"

module tb_mult_top
  import mult_op_pkg::*;
();

  localparam int unsigned CLK_PERIOD   = 20;
  localparam int unsigned DRIVE_DLY    = 1;
  localparam int unsigned RESET_CYCLES = 4;
  localparam int unsigned RAND_SEED    = 84254;
  localparam int unsigned N_INT        = 200;
  localparam int unsigned N_SUB        = 300;
  localparam int unsigned N_MULH       = 60;
  localparam int unsigned N_DOT        = 200;
  localparam int unsigned N_BP         = 30;
  localparam int unsigned MAX_HOLD     = 5;
  // an upper-half run takes five cycles plus its hold time
  localparam int unsigned RUN_CYCLES   = 3 * RESET_CYCLES + N_INT + N_SUB + N_DOT
                                         + 5 * N_MULH + (5 + MAX_HOLD) * (N_BP + 2) + 10;
  localparam int unsigned WATCHDOG_NS  = (RUN_CYCLES + 100) * CLK_PERIOD;

  logic                  clk;
  logic                  rst_n;
  logic                  enable_i;
  mult_op_e              operator_i;
  logic                  short_subword_i;
  sign_mode_e            short_signed_i;
  sign_mode_e            dot_signed_i;
  logic [`MULT_DW-1:0]   op_a_i;
  logic [`MULT_DW-1:0]   op_b_i;
  logic [`MULT_DW-1:0]   op_c_i;
  logic [`MULT_IMMW-1:0] imm_i;
  logic                  ex_ready_i;
  logic [`MULT_DW-1:0]   result_o;
  logic                  ready_o;
  logic                  multicycle_o;

  // expectations set alongside the stimulus
  // mh_phase 1 start, 2..4 steps, 5 finish, 0 no upper-half op
  logic                  chk_comb;
  logic                  hold_chk;
  logic [2:0]            mh_phase;
  logic [`MULT_DW-1:0]   exp_result;
  int                    errors;
  int                    vectors;

  mult_top mult_top_inst (
    .clk             (clk),
    .rst_n           (rst_n),
    .enable_i        (enable_i),
    .operator_i      (operator_i),
    .short_subword_i (short_subword_i),
    .short_signed_i  (short_signed_i),
    .dot_signed_i    (dot_signed_i),
    .op_a_i          (op_a_i),
    .op_b_i          (op_b_i),
    .op_c_i          (op_c_i),
    .imm_i           (imm_i),
    .ex_ready_i      (ex_ready_i),
    .result_o        (result_o),
    .ready_o         (ready_o),
    .multicycle_o    (multicycle_o)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #(CLK_PERIOD / 2) clk = ~clk;
    end
  end

  ////////////////////////////////////////
  // reference models
  ////////////////////////////////////////

  // low word of c +/- a*b
  function automatic logic [31:0] int_mac_ref(input mult_op_e op,
                                              input logic [31:0] a, b, c);
    if (op == MUL_MSU32) begin
      return c - a * b;
    end
    return c + a * b;
  endfunction

  // halfword product plus c and rounding, low word shifted, sign from bit 31
  function automatic logic [31:0] subword_ref(input mult_op_e op, input logic [31:0] a, b, c,
                                              input logic hi, input sign_mode_e sgn,
                                              input logic [4:0] imm);
    logic [15:0] ha;
    logic [15:0] hb;
    logic [31:0] ea;
    logic [31:0] eb;
    logic [31:0] rnd;
    logic [31:0] sum;
    ha  = hi ? a[31:16] : a[15:0];
    hb  = hi ? b[31:16] : b[15:0];
    ea  = {{16{sgn[0] & ha[15]}}, ha};
    eb  = {{16{sgn[1] & hb[15]}}, hb};
    rnd = (op == MUL_IR && imm != 5'd0) ? (32'd1 << (imm - 5'd1)) : 32'd0;
    sum = c + ea * eb + rnd;
    if (sgn[0]) begin
      return $signed(sum) >>> imm;
    end
    return sum >> imm;
  endfunction

  // upper word of the 64-bit product
  function automatic logic [31:0] upper_half_ref(input logic [31:0] a, b,
                                                 input sign_mode_e sgn);
    logic [63:0] ea;
    logic [63:0] eb;
    logic [63:0] prod;
    ea   = {{32{sgn[0] & a[31]}}, a};
    eb   = {{32{sgn[1] & b[31]}}, b};
    prod = ea * eb;
    return prod[63:32];
  endfunction

  function automatic logic [31:0] byte_dot_ref(input logic [31:0] a, b, c,
                                               input sign_mode_e sgn);
    logic [31:0] acc;
    logic [7:0]  ba;
    logic [7:0]  bb;
    acc = c;
    for (int k = 0; k < 4; k++) begin
      ba  = a[8*k +: 8];
      bb  = b[8*k +: 8];
      acc = acc + {{24{sgn[0] & ba[7]}}, ba} * {{24{sgn[1] & bb[7]}}, bb};
    end
    return acc;
  endfunction

  function automatic logic [31:0] half_dot_ref(input logic [31:0] a, b, c,
                                               input sign_mode_e sgn);
    logic [31:0] acc;
    logic [15:0] ha;
    logic [15:0] hb;
    acc = c;
    for (int k = 0; k < 2; k++) begin
      ha  = a[16*k +: 16];
      hb  = b[16*k +: 16];
      acc = acc + {{16{sgn[0] & ha[15]}}, ha} * {{16{sgn[1] & hb[15]}}, hb};
    end
    return acc;
  endfunction

  // only the three legal modes, never b signed alone
  function automatic sign_mode_e sign_from(input int unsigned sel);
    case (sel % 3)
      0:       return SGN_UU;
      1:       return SGN_SU;
      default: return SGN_SS;
    endcase
  endfunction

  ////////////////////////////////////////
  // checks on the falling edge
  ////////////////////////////////////////

  task automatic log_mismatch(input string sig, input logic [31:0] expv,
                              input logic [31:0] gotv);
    errors++;
    $display("Mismatch at %0t: %s expected %h, got %h", $time, sig, expv, gotv);
  endtask

  a_comb_result: assert property (@(negedge clk) disable iff (!rst_n)
    chk_comb |-> result_o == exp_result)
    else log_mismatch("result_o", exp_result, result_o);

  a_comb_ready: assert property (@(negedge clk) disable iff (!rst_n)
    chk_comb |-> ready_o)
    else log_mismatch("ready_o", 32'd1, 32'(ready_o));

  a_start_ready: assert property (@(negedge clk) disable iff (!rst_n)
    mh_phase == 3'd1 |-> !ready_o)
    else log_mismatch("ready_o", 32'd0, 32'(ready_o));

  // the three partial-product steps
  a_step_multicycle: assert property (@(negedge clk) disable iff (!rst_n)
    (mh_phase >= 3'd2 && mh_phase <= 3'd4) |-> multicycle_o)
    else log_mismatch("multicycle_o", 32'd1, 32'(multicycle_o));

  a_step_ready: assert property (@(negedge clk) disable iff (!rst_n)
    (mh_phase >= 3'd2 && mh_phase <= 3'd4) |-> !ready_o)
    else log_mismatch("ready_o", 32'd0, 32'(ready_o));

  a_finish_ready: assert property (@(negedge clk) disable iff (!rst_n)
    mh_phase == 3'd5 |-> ready_o)
    else log_mismatch("ready_o", 32'd1, 32'(ready_o));

  a_finish_result: assert property (@(negedge clk) disable iff (!rst_n)
    mh_phase == 3'd5 |-> result_o == exp_result)
    else log_mismatch("result_o", exp_result, result_o);

  a_hold_stable: assert property (@(negedge clk) disable iff (!rst_n)
    hold_chk |-> $stable(result_o) && $stable(ready_o))
    else begin
      errors++;
      $display("result or ready changed at %0t while the core held off", $time);
    end

  // idle and also the whole reset phase
  a_idle_ready: assert property (@(negedge clk)
    (!rst_n || mh_phase == 3'd0) |-> ready_o)
    else log_mismatch("ready_o", 32'd1, 32'(ready_o));

  a_idle_multicycle: assert property (@(negedge clk)
    (!rst_n || mh_phase == 3'd0 || mh_phase == 3'd1 || mh_phase == 3'd5) |-> !multicycle_o)
    else log_mismatch("multicycle_o", 32'd0, 32'(multicycle_o));

  ////////////////////////////////////////
  // stimulus helpers
  ////////////////////////////////////////

  task automatic next_slot();
    @(posedge clk);
    #(DRIVE_DLY);
  endtask

  task automatic randomize_inputs();
    enable_i        = 1'b1;
    ex_ready_i      = 1'b1;
    op_a_i          = $urandom;
    op_b_i          = $urandom;
    op_c_i          = $urandom;
    imm_i           = `MULT_IMMW'($urandom);
    short_subword_i = 1'($urandom);
    short_signed_i  = sign_from($urandom);
    dot_signed_i    = sign_from($urandom);
  endtask

  task automatic drive_idle();
    next_slot();
    chk_comb   = 1'b0;
    hold_chk   = 1'b0;
    mh_phase   = 3'd0;
    enable_i   = 1'b0;
    ex_ready_i = 1'b1;
    operator_i = MUL_MAC32;
  endtask

  // one upper-half product, finish held for hold cycles before the core takes it
  task automatic run_upper_half(input sign_mode_e mode, input int hold);
    next_slot();
    randomize_inputs();
    operator_i     = MUL_H;
    short_signed_i = mode;
    ex_ready_i     = 1'b0;
    chk_comb       = 1'b0;
    hold_chk       = 1'b0;
    exp_result     = upper_half_ref(op_a_i, op_b_i, mode);
    mh_phase       = 3'd1;
    repeat (3) begin
      next_slot();
      mh_phase = mh_phase + 3'd1;
    end
    for (int h = 0; h <= hold; h++) begin
      next_slot();
      mh_phase   = 3'd5;
      hold_chk   = (h > 0);
      ex_ready_i = (h == hold);
    end
    vectors++;
  endtask

  task automatic report_test(input string name, input int n, input int err_mark);
    $display("test %s: %0d vectors, %0d errors", name, n, errors - err_mark);
  endtask

  ////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////

  initial begin
    int err_mark;
    int hold;
    void'($urandom(RAND_SEED));
    errors          = 0;
    vectors         = 0;
    rst_n           = 1'b1;
    enable_i        = 1'b0;
    operator_i      = MUL_MAC32;
    short_subword_i = 1'b0;
    short_signed_i  = SGN_UU;
    dot_signed_i    = SGN_UU;
    op_a_i          = '0;
    op_b_i          = '0;
    op_c_i          = '0;
    imm_i           = '0;
    ex_ready_i      = 1'b1;
    chk_comb        = 1'b0;
    hold_chk        = 1'b0;
    mh_phase        = 3'd0;
    exp_result      = '0;
    #(DRIVE_DLY);
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #(DRIVE_DLY);
    rst_n = 1'b1;

    err_mark = errors;
    for (int i = 0; i < N_INT; i++) begin
      next_slot();
      randomize_inputs();
      operator_i = ($urandom % 2 == 0) ? MUL_MAC32 : MUL_MSU32;
      exp_result = int_mac_ref(operator_i, op_a_i, op_b_i, op_c_i);
      chk_comb   = 1'b1;
      vectors++;
    end
    drive_idle();
    report_test("integer mac/msu", N_INT, err_mark);

    err_mark = errors;
    for (int i = 0; i < N_SUB; i++) begin
      next_slot();
      randomize_inputs();
      operator_i = ($urandom % 2 == 0) ? MUL_I : MUL_IR;
      exp_result = subword_ref(operator_i, op_a_i, op_b_i, op_c_i, short_subword_i,
                               short_signed_i, imm_i);
      chk_comb   = 1'b1;
      vectors++;
    end
    drive_idle();
    report_test("subword mac with shift", N_SUB, err_mark);

    // cycle through uu, su and ss
    err_mark = errors;
    for (int i = 0; i < N_MULH; i++) begin
      run_upper_half(sign_from(i), 0);
    end
    drive_idle();
    report_test("upper-half product", N_MULH, err_mark);

    err_mark = errors;
    for (int i = 0; i < N_DOT; i++) begin
      next_slot();
      randomize_inputs();
      if ($urandom % 2 == 0) begin
        operator_i = MUL_DOT8;
        exp_result = byte_dot_ref(op_a_i, op_b_i, op_c_i, dot_signed_i);
      end else begin
        operator_i = MUL_DOT16;
        exp_result = half_dot_ref(op_a_i, op_b_i, op_c_i, dot_signed_i);
      end
      chk_comb = 1'b1;
      vectors++;
    end
    drive_idle();
    report_test("dot products", N_DOT, err_mark);

    // back-to-back runs show the carry does not leak
    err_mark = errors;
    for (int i = 0; i < N_BP; i++) begin
      hold = 1 + int'($urandom % MAX_HOLD);
      run_upper_half(sign_from($urandom), hold);
    end
    // reset in the middle of a sequence, then a clean run
    next_slot();
    randomize_inputs();
    operator_i = MUL_H;
    ex_ready_i = 1'b0;
    chk_comb   = 1'b0;
    hold_chk   = 1'b0;
    mh_phase   = 3'd1;
    next_slot();
    mh_phase = 3'd2;
    next_slot();
    mh_phase = 3'd0;
    rst_n    = 1'b0;
    enable_i = 1'b0;
    repeat (RESET_CYCLES) next_slot();
    rst_n = 1'b1;
    run_upper_half(SGN_SS, 0);
    drive_idle();
    report_test("back-pressure and reset", N_BP + 1, err_mark);

    $display("all tests: %0d vectors, %0d errors", vectors, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired at %0t, the run did not finish in time", $time);
    $display("TESTS FAILED");
    $finish;
  end

endmodule

/* mult.f */
+incdir+.
mult_op_pkg.sv
mult_ctrl_pkg.sv
mulh_seq.sv
short_mac.sv
word_mac.sv
mult_top.sv
tb_mult_top.sv

/* run_sim.sh */
#!/bin/sh
# build the multiplier testbench with Verilator and run it
# pass only when the pass message shows up in the simulation output

cd "$(dirname "$0")" &&
verilator --binary --timing --assert -j 0 --top-module tb_mult_top -f mult.f &&
./obj_dir/Vtb_mult_top | tee /dev/stderr | grep -q "^TESTS PASSED$" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
